// ==== compile.f ====
+incdir+design
design/replica_pkg.sv
design/schedule_if.sv
design/run_sequencer.sv
design/cycle_timer.sv
design/distance_cmd_gen.sv
design/recip_sequencer.sv
design/replica_node_top.sv
testbench/replica_node_tb.sv

// ==== design/cycle_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_defines.svh"

module cycle_timer (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    schedule_if.timer  sched,
    output logic       or_metropolis_run,
    output logic       tw_metropolis_run,
    output logic       or_replica_run,
    output logic       tw_replica_run,
    output logic       or_exchange_run,
    output logic       tw_exchange_run,
    output logic       exp_fin
);

    logic [`CYCLE_W-1:0] cycle_cnt;

    // 0 means no pass in progress
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= '0;
        end else if (start) begin
            cycle_cnt <= `CYCLE_W'(1);
        end else if (cycle_cnt == `CYCLE_W'(`PASS_LAST)) begin
            cycle_cnt <= '0;
        end else if (cycle_cnt != '0) begin
            cycle_cnt <= cycle_cnt + `CYCLE_W'(1);
        end
    end

    assign sched.stage_tick  = (cycle_cnt % `STAGE_PERIOD == 0) && (cycle_cnt != '0);
    assign sched.pass_finish = (cycle_cnt == `CYCLE_W'(`PASS_LAST));
    assign sched.move_two    = (cycle_cnt == `CYCLE_W'(`SCHED_TW_START));
    assign sched.move_idle   = (cycle_cnt == `CYCLE_W'(`SCHED_OR_IDLE))
                            || (cycle_cnt == `CYCLE_W'(`SCHED_TW_IDLE));
    assign sched.exp_init    = (cycle_cnt == `CYCLE_W'(`SCHED_EXP_INIT_0))
                            || (cycle_cnt == `CYCLE_W'(`SCHED_EXP_INIT_1))
                            || (cycle_cnt == `CYCLE_W'(`SCHED_EXP_INIT_2))
                            || (cycle_cnt == `CYCLE_W'(`SCHED_EXP_INIT_3));

    assign or_metropolis_run = (cycle_cnt == `CYCLE_W'(`SCHED_OR_METRO));
    assign tw_metropolis_run = (cycle_cnt == `CYCLE_W'(`SCHED_TW_METRO));
    assign or_replica_run    = (cycle_cnt == `CYCLE_W'(`SCHED_OR_REPLICA));
    assign tw_replica_run    = (cycle_cnt == `CYCLE_W'(`SCHED_TW_REPLICA));
    assign or_exchange_run   = (cycle_cnt == `CYCLE_W'(`SCHED_OR_EXCHANGE));
    assign tw_exchange_run   = (cycle_cnt == `CYCLE_W'(`SCHED_TW_EXCHANGE));

    // one per stage, none in the slot just before the pass ends
    assign exp_fin = (cycle_cnt % `STAGE_PERIOD == `EXP_FIN_SLOT)
                  && (cycle_cnt != '0)
                  && (cycle_cnt < `CYCLE_W'(`PASS_LAST - 1));

endmodule

`default_nettype wire

// ==== design/distance_cmd_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_defines.svh"

module distance_cmd_gen (
    input  logic                           clk,
    input  logic                           opt_run,
    output replica_pkg::distance_command_t or_distance_com,
    output replica_pkg::distance_command_t tw_distance_com
);
    import replica_pkg::*;

    logic [`STAGE_W-1:0] stage_cnt;

    // free running, realigned by each opt_run
    always_ff @(posedge clk) begin
        if (opt_run) begin
            stage_cnt <= '0;
        end else begin
            stage_cnt <= stage_cnt + `STAGE_W'(1);
        end
    end

    // or-opt: break three edges, join three
    always_ff @(posedge clk) begin
        case (stage_cnt)
            `STAGE_W'(0): or_distance_com <= distance_command_t'{KN, ZERO};
            `STAGE_W'(1): or_distance_com <= distance_command_t'{KM, MNS};
            `STAGE_W'(2): or_distance_com <= distance_command_t'{KP, PLS};
            `STAGE_W'(3): or_distance_com <= distance_command_t'{KN, MNS};
            `STAGE_W'(4): or_distance_com <= distance_command_t'{LN, PLS};
            `STAGE_W'(5): or_distance_com <= distance_command_t'{LP, MNS};
            `STAGE_W'(6): or_distance_com <= distance_command_t'{KN, PLS};
            default:      or_distance_com <= distance_command_t'{KN, DNOP};
        endcase
    end

    // two-opt: swap two edges
    always_ff @(posedge clk) begin
        case (stage_cnt)
            `STAGE_W'(0): tw_distance_com <= distance_command_t'{KN, ZERO};
            `STAGE_W'(1): tw_distance_com <= distance_command_t'{KM, MNS};
            `STAGE_W'(2): tw_distance_com <= distance_command_t'{LM, PLS};
            `STAGE_W'(3): tw_distance_com <= distance_command_t'{LN, MNS};
            `STAGE_W'(4): tw_distance_com <= distance_command_t'{KN, PLS};
            default:      tw_distance_com <= distance_command_t'{KN, DNOP};
        endcase
    end

endmodule

`default_nettype wire

// ==== design/recip_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_defines.svh"

module recip_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    schedule_if.user             sched,
    output logic                 exp_run,
    output logic [`RECIP_W-1:0]  exp_recip
);

    logic [`TERM_W-1:0] term;
    logic [`TERM_W-1:0] term_next;

    // 1/k in fixed point, k = 0 is never streamed
    function automatic logic [`RECIP_W-1:0] recip_of(input logic [`TERM_W-1:0] k);
        case (k)
            `TERM_W'(1):  recip_of = `RECIP_W'(`RECIP_ONE / 1);
            `TERM_W'(2):  recip_of = `RECIP_W'(`RECIP_ONE / 2);
            `TERM_W'(3):  recip_of = `RECIP_W'(`RECIP_ONE / 3);
            `TERM_W'(4):  recip_of = `RECIP_W'(`RECIP_ONE / 4);
            `TERM_W'(5):  recip_of = `RECIP_W'(`RECIP_ONE / 5);
            `TERM_W'(6):  recip_of = `RECIP_W'(`RECIP_ONE / 6);
            `TERM_W'(7):  recip_of = `RECIP_W'(`RECIP_ONE / 7);
            `TERM_W'(8):  recip_of = `RECIP_W'(`RECIP_ONE / 8);
            `TERM_W'(9):  recip_of = `RECIP_W'(`RECIP_ONE / 9);
            `TERM_W'(10): recip_of = `RECIP_W'(`RECIP_ONE / 10);
            `TERM_W'(11): recip_of = `RECIP_W'(`RECIP_ONE / 11);
            `TERM_W'(12): recip_of = `RECIP_W'(`RECIP_ONE / 12);
            `TERM_W'(13): recip_of = `RECIP_W'(`RECIP_ONE / 13);
            `TERM_W'(14): recip_of = `RECIP_W'(`RECIP_ONE / 14);
            `TERM_W'(15): recip_of = `RECIP_W'(`RECIP_ONE / 15);
            default:      recip_of = '0;
        endcase
    endfunction

    assign term_next = sched.exp_init ? `TERM_W'(`EXP_TERMS) :
                       (term != '0)   ? term - `TERM_W'(1)     : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            term <= '0;
        end else begin
            term <= term_next;
        end
    end

    // word for term k appears together with term k
    always_ff @(posedge clk) begin
        exp_recip <= recip_of(term_next);
    end

    assign exp_run = (term != '0);

endmodule

`default_nettype wire

// ==== design/replica_defines.svh ====
`ifndef REPLICA_DEFINES_SVH
`define REPLICA_DEFINES_SVH

// run length and pass timing
`define RUN_TIMES_W     24
`define STEPS_PER_PASS  2
`define CYCLE_W         8
`define PASS_LAST       199
`define STAGE_PERIOD    20
`define EXP_FIN_SLOT    18

// schedule points within a pass
`define SCHED_OR_IDLE       19
`define SCHED_TW_START      99
`define SCHED_TW_IDLE       119
`define SCHED_OR_METRO      58
`define SCHED_TW_METRO      158
`define SCHED_OR_REPLICA    78
`define SCHED_TW_REPLICA    178
`define SCHED_OR_EXCHANGE   80
`define SCHED_TW_EXCHANGE   180

// series starts for the exponential unit
`define SCHED_EXP_INIT_0    40
`define SCHED_EXP_INIT_1    60
`define SCHED_EXP_INIT_2    140
`define SCHED_EXP_INIT_3    160

// distance stage counter and reciprocal stream
`define STAGE_W     5
`define RECIP_W     17
`define RECIP_ONE   32768
`define EXP_TERMS   15
`define TERM_W      4

`endif

// ==== design/replica_node_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_defines.svh"

module replica_node_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           run_write,
    input  logic [`RUN_TIMES_W-1:0]        run_times,
    output logic                           running,
    output logic                           opt_run,
    output replica_pkg::opt_command_t      opt_com,
    output replica_pkg::opt_command_t      opt_command,
    output replica_pkg::distance_command_t or_distance_com,
    output replica_pkg::distance_command_t tw_distance_com,
    output logic                           or_metropolis_run,
    output logic                           tw_metropolis_run,
    output logic                           or_replica_run,
    output logic                           tw_replica_run,
    output logic                           or_exchange_run,
    output logic                           tw_exchange_run,
    output logic                           exp_init,
    output logic                           exp_run,
    output logic                           exp_fin,
    output logic [`RECIP_W-1:0]            exp_recip
);

    schedule_if sched ();

    logic start;

    run_sequencer u_run_sequencer (
        .clk         (clk),
        .reset       (reset),
        .run_write   (run_write),
        .run_times   (run_times),
        .sched       (sched.user),
        .start       (start),
        .running     (running),
        .opt_run     (opt_run),
        .opt_com     (opt_com),
        .opt_command (opt_command)
    );

    cycle_timer u_cycle_timer (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .sched             (sched.timer),
        .or_metropolis_run (or_metropolis_run),
        .tw_metropolis_run (tw_metropolis_run),
        .or_replica_run    (or_replica_run),
        .tw_replica_run    (tw_replica_run),
        .or_exchange_run   (or_exchange_run),
        .tw_exchange_run   (tw_exchange_run),
        .exp_fin           (exp_fin)
    );

    distance_cmd_gen u_distance_cmd_gen (
        .clk             (clk),
        .opt_run         (opt_run),
        .or_distance_com (or_distance_com),
        .tw_distance_com (tw_distance_com)
    );

    recip_sequencer u_recip_sequencer (
        .clk       (clk),
        .reset     (reset),
        .sched     (sched.user),
        .exp_run   (exp_run),
        .exp_recip (exp_recip)
    );

    assign exp_init = sched.exp_init;

endmodule

`default_nettype wire

// ==== design/replica_pkg.sv ====
`default_nettype none

package replica_pkg;

    // move under optimisation, THR when nothing is in progress
    typedef enum logic [1:0] {
        OR1,
        TWO,
        THR
    } opt_command_t;

    // tour distance term addressed by a command
    typedef enum logic [2:0] {
        KN,
        KM,
        KP,
        LN,
        LP,
        LM
    } dist_select_t;

    typedef enum logic [1:0] {
        ZERO,
        MNS,
        PLS,
        DNOP
    } dist_op_t;

    typedef struct packed {
        dist_select_t select;
        dist_op_t     op;
    } distance_command_t;

endpackage

`default_nettype wire

// ==== design/run_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_defines.svh"

module run_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run_write,
    input  logic [`RUN_TIMES_W-1:0]   run_times,
    schedule_if.user                  sched,
    output logic                      start,
    output logic                      running,
    output logic                      opt_run,
    output replica_pkg::opt_command_t opt_com,
    output replica_pkg::opt_command_t opt_command
);
    import replica_pkg::*;

    // S_FINISH covers the last pass of a run
    typedef enum logic [1:0] {
        S_IDLE,
        S_PASS,
        S_FINISH
    } state_t;

    state_t                  state;
    logic [`RUN_TIMES_W-1:0] run_times_reg;
    logic [`RUN_TIMES_W-1:0] step_cnt;
    logic [`RUN_TIMES_W-1:0] step_next;
    logic                    next_is_last;

    assign step_next    = step_cnt + `RUN_TIMES_W'(`STEPS_PER_PASS);
    assign next_is_last = (step_next + `RUN_TIMES_W'(`STEPS_PER_PASS)) == run_times_reg;

    assign running = (state != S_IDLE);
    assign opt_run = start | sched.stage_tick;

    always_ff @(posedge clk) begin
        start <= 1'b0;
        if (reset) begin
            state       <= S_IDLE;
            step_cnt    <= '0;
            opt_com     <= THR;
            opt_command <= THR;
        end else if (run_write) begin
            // a write restarts the run even while one is going
            state         <= (run_times == `RUN_TIMES_W'(`STEPS_PER_PASS)) ? S_FINISH : S_PASS;
            run_times_reg <= run_times;
            step_cnt      <= '0;
            start         <= 1'b1;
            opt_com       <= OR1;
            opt_command   <= OR1;
        end else if (state != S_IDLE) begin
            if (sched.move_idle) begin
                opt_com <= THR;
            end
            if (sched.move_two) begin
                opt_com     <= TWO;
                opt_command <= TWO;
            end
            if (sched.pass_finish) begin
                step_cnt <= step_next;
                if (state == S_FINISH) begin
                    state       <= S_IDLE;
                    opt_com     <= THR;
                    opt_command <= THR;
                end else begin
                    state       <= next_is_last ? S_FINISH : S_PASS;
                    start       <= 1'b1;
                    opt_com     <= OR1;
                    opt_command <= OR1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/schedule_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface schedule_if;

    // one-cycle strobes decoded from the pass cycle count
    logic stage_tick;
    logic pass_finish;
    logic move_two;
    logic move_idle;
    logic exp_init;

    modport timer (
        output stage_tick,
        output pass_finish,
        output move_two,
        output move_idle,
        output exp_init
    );

    modport user (
        input stage_tick,
        input pass_finish,
        input move_two,
        input move_idle,
        input exp_init
    );

endinterface

`default_nettype wire

// ==== testbench/replica_node_cases.txt ====
# columns: run_times  expected_passes  idle_gap_cycles
# a gap of 0 picks a random idle gap
2 1 10
4 2 0
6 3 3
2 1 0
10 5 7
8 4 0
2 1 1

// ==== testbench/replica_node_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "replica_defines.svh"

module replica_node_tb;
    import replica_pkg::*;

    localparam int PASS_CYCLES = 200;
    localparam int MAX_CASES   = 32;

    logic                    clk;
    logic                    reset;
    logic                    run_write;
    logic [`RUN_TIMES_W-1:0] run_times;
    logic                    running;
    logic                    opt_run;
    opt_command_t            opt_com;
    opt_command_t            opt_command;
    distance_command_t       or_distance_com;
    distance_command_t       tw_distance_com;
    logic                    or_metropolis_run;
    logic                    tw_metropolis_run;
    logic                    or_replica_run;
    logic                    tw_replica_run;
    logic                    or_exchange_run;
    logic                    tw_exchange_run;
    logic                    exp_init;
    logic                    exp_run;
    logic                    exp_fin;
    logic [`RECIP_W-1:0]     exp_recip;

    int case_times [MAX_CASES];
    int case_passes [MAX_CASES];
    int case_gap [MAX_CASES];
    int num_cases;
    int errors;
    int checks;
    int cycle_cnt;
    int cycle_limit;

    // monitor state for the running case
    int         strobe_cnt [6];
    int         burst_cnt;
    int         burst_len;
    int         fin_cnt;
    int         next_term;
    int         dist_pos;
    logic       prev_exp_run;
    logic       prev_exp_init;
    logic [5:0] strobes;
    logic [4:0] or_table [7];
    logic [4:0] tw_table [5];

    replica_node_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check("running", running, 0);
        check("opt_run", opt_run, 0);
        check("exp_run", exp_run, 0);
        check("exp_init", exp_init, 0);
        check("exp_fin", exp_fin, 0);
        check("move strobes", {or_metropolis_run, tw_metropolis_run, or_replica_run,
                               tw_replica_run, or_exchange_run, tw_exchange_run}, 0);
        check("opt_com", opt_com, THR);
        check("opt_command", opt_command, THR);
    endtask

    task automatic read_cases();
        int fd;
        int rt;
        int np;
        int gp;
        logic [8*128-1:0] line;
        fd = $fopen("testbench/replica_node_cases.txt", "r");
        num_cases = 0;
        cycle_limit = 50;
        if (fd == 0) begin
            errors++;
            $display("could not open the cases file");
        end else begin
            // comment lines do not parse as numbers and are skipped
            while ($fgets(line, fd) != 0 && num_cases < MAX_CASES) begin
                if ($sscanf(line, "%d %d %d", rt, np, gp) == 3) begin
                    if (gp == 0)
                        gp = 4 + ($urandom % 29);
                    case_times[num_cases] = rt;
                    case_passes[num_cases] = np;
                    case_gap[num_cases] = gp;
                    cycle_limit += PASS_CYCLES * np + gp + 50;
                    num_cases++;
                end
            end
            $fclose(fd);
            if (num_cases == 0) begin
                errors++;
                $display("the cases file holds no runs");
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // sample everything half a cycle after the DUT updates
    always @(negedge clk) begin
        if (!reset) begin
            strobes = {tw_exchange_run, or_exchange_run, tw_replica_run,
                       or_replica_run, tw_metropolis_run, or_metropolis_run};
            for (int i = 0; i < 6; i++) begin
                if (strobes[i])
                    strobe_cnt[i]++;
            end
            if (exp_fin)
                fin_cnt++;
            if (or_exchange_run)
                check("opt_command at or_exchange_run", opt_command, OR1);
            if (tw_exchange_run)
                check("opt_command at tw_exchange_run", opt_command, TWO);
            if (or_metropolis_run || tw_metropolis_run)
                check("opt_com at metropolis_run", opt_com, THR);

            if (prev_exp_init)
                check("exp_run burst start", exp_run && !prev_exp_run, 1);
            if (exp_run) begin
                if (!prev_exp_run) begin
                    burst_cnt++;
                    burst_len = 0;
                    next_term = `EXP_TERMS;
                end
                burst_len++;
                if (next_term > 0)
                    check("exp_recip", exp_recip, `RECIP_ONE / next_term);
                next_term--;
            end else if (prev_exp_run) begin
                check("exp_run burst length", burst_len, `EXP_TERMS);
            end
            prev_exp_run = exp_run;
            prev_exp_init = exp_init;

            // stage 0 command shows two samples after opt_run
            if (dist_pos >= 0 && dist_pos < 7)
                check("or_distance_com", or_distance_com, or_table[dist_pos]);
            if (dist_pos >= 0 && dist_pos < 5)
                check("tw_distance_com", tw_distance_com, tw_table[dist_pos]);
            if (opt_run)
                dist_pos = -1;
            else if (dist_pos < 100)
                dist_pos++;
        end
    end

    initial begin : main
        int k;
        int high;
        int case_err;
        void'($urandom(16));
        reset = 1'b1;
        run_write = 1'b0;
        run_times = '0;
        errors = 0;
        checks = 0;
        cycle_cnt = 0;
        cycle_limit = 0;
        dist_pos = 100;
        prev_exp_run = 1'b0;
        prev_exp_init = 1'b0;
        or_table[0] = {KN, ZERO};
        or_table[1] = {KM, MNS};
        or_table[2] = {KP, PLS};
        or_table[3] = {KN, MNS};
        or_table[4] = {LN, PLS};
        or_table[5] = {LP, MNS};
        or_table[6] = {KN, PLS};
        tw_table[0] = {KN, ZERO};
        tw_table[1] = {KM, MNS};
        tw_table[2] = {LM, PLS};
        tw_table[3] = {LN, MNS};
        tw_table[4] = {KN, PLS};
        read_cases();

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end

        for (k = 0; k < num_cases; k++) begin
            case_err = errors;
            repeat (case_gap[k]) @(posedge clk);
            for (int i = 0; i < 6; i++)
                strobe_cnt[i] = 0;
            burst_cnt = 0;
            fin_cnt = 0;
            run_write <= 1'b1;
            run_times <= case_times[k];
            @(posedge clk);
            run_write <= 1'b0;
            @(negedge clk);
            check("running at start", running, 1);
            high = 0;
            while (running) begin
                high++;
                @(negedge clk);
            end
            check("running cycles", high, PASS_CYCLES * case_passes[k]);
            check("opt_com after run", opt_com, THR);
            check("opt_command after run", opt_command, THR);
            check("or_metropolis_run pulses", strobe_cnt[0], case_passes[k]);
            check("tw_metropolis_run pulses", strobe_cnt[1], case_passes[k]);
            check("or_replica_run pulses", strobe_cnt[2], case_passes[k]);
            check("tw_replica_run pulses", strobe_cnt[3], case_passes[k]);
            check("or_exchange_run pulses", strobe_cnt[4], case_passes[k]);
            check("tw_exchange_run pulses", strobe_cnt[5], case_passes[k]);
            check("exp_run bursts", burst_cnt, 4 * case_passes[k]);
            check("exp_fin pulses", fin_cnt, 9 * case_passes[k]);
            $display("case %0d: run_times %0d, %0d passes, gap %0d, %0s", k, case_times[k],
                     case_passes[k], case_gap[k], (errors == case_err) ? "ok" : "failed");
        end

        $display("%0d cases, %0d checks, %0d errors", num_cases, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
